// File: include/mem_params.svh
/* Memory map and latency of the data scratchpad.
   Included by the RTL and the testbench. */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Memory map
`define DMEM_BASE     40'h80000000   // First RAM address, also end of I/O space
`define DMEM_BYTES    512            // 64 doublewords of RAM
`define DMEM_IO_BASE  40'h40000000   // Lowest device address

// Cycles from accepted request to response, 2 or more
`define DMEM_LATENCY  3

`endif

// File: src/mem_pkg.sv
/* Types shared by the data-memory path: instructions, cache commands,
   FSM states and the CPU request and response structs. */
`default_nettype none

package mem_pkg;

    typedef logic [63:0] bus64_t;
    typedef logic [39:0] addr_t;   // Physical address

    // Memory instructions from execute
    typedef enum logic [5:0] {
        LD, LW, LWU, LH, LHU, LB, LBU,
        SD, SW, SH, SB,
        AMO_LRW, AMO_LRD, AMO_SCW, AMO_SCD,
        AMO_SWAPW, AMO_SWAPD, AMO_ADDW, AMO_ADDD,
        AMO_XORW, AMO_XORD, AMO_ANDW, AMO_ANDD,
        AMO_ORW, AMO_ORD, AMO_MINW, AMO_MIND,
        AMO_MAXW, AMO_MAXD, AMO_MINWU, AMO_MINDU,
        AMO_MAXWU, AMO_MAXDU
    } instr_type_t;

    // Data cache commands
    typedef enum logic [4:0] {
        DCMD_LOAD    = 5'b00000,
        DCMD_STORE   = 5'b00001,
        DCMD_AMOSWAP = 5'b00100,
        DCMD_LR      = 5'b00110,
        DCMD_SC      = 5'b00111,
        DCMD_AMOADD  = 5'b01000,
        DCMD_AMOXOR  = 5'b01001,
        DCMD_AMOOR   = 5'b01010,
        DCMD_AMOAND  = 5'b01011,
        DCMD_AMOMIN  = 5'b01100,
        DCMD_AMOMAX  = 5'b01101,
        DCMD_AMOMINU = 5'b01110,
        DCMD_AMOMAXU = 5'b01111
    } dcache_cmd_t;

    typedef enum logic [1:0] {MEM_NOP, MEM_LOAD, MEM_STORE, MEM_AMO} mem_op_t;

    typedef enum logic [1:0] {RESET_STATE, IDLE, MAKE_REQUEST, WAIT_RESPONSE} dcache_if_state_t;

    // Execute stage to interface
    typedef struct packed {
        logic        valid;
        logic        kill;          // Squash the instruction
        instr_type_t instr_type;
        bus64_t      data_rs1;
        bus64_t      data_rs2;      // Store data or AMO operand
        bus64_t      imm;
        logic [2:0]  mem_size;      // [1:0] log2 bytes, [2] unsigned
        logic [4:0]  rd;
        addr_t       io_base_addr;
    } req_cpu_dcache_t;

    // Interface back to the CPU
    typedef struct packed {
        logic   ready;      // Result valid
        logic   lock;       // Hold the pipeline
        bus64_t data;
        bus64_t addr;       // Effective address
        logic   xcpt_ma_st;
        logic   xcpt_ma_ld;
        logic   xcpt_pf_st;
        logic   xcpt_pf_ld;
    } resp_dcache_cpu_t;

endpackage

`default_nettype wire

// File: src/amo_alu.sv
/* Read-modify-write datapath for the AMO commands.
   Word mode works on the low half and sign-extends the result. */
`default_nettype none

module amo_alu (
    input  mem_pkg::dcache_cmd_t cmd_i,
    input  logic                 word_i,      // 32-bit operation
    input  mem_pkg::bus64_t      mem_data_i,  // Old memory value
    input  mem_pkg::bus64_t      operand_i,   // rs2
    output mem_pkg::bus64_t      result_o
);

    mem_pkg::bus64_t a, b, res;

    // Sign-extending both halves keeps signed and unsigned ordering intact
    assign a = word_i ? {{32{mem_data_i[31]}}, mem_data_i[31:0]} : mem_data_i;
    assign b = word_i ? {{32{operand_i[31]}}, operand_i[31:0]} : operand_i;

    always_comb begin
        case (cmd_i)
            mem_pkg::DCMD_AMOADD:  res = a + b;
            mem_pkg::DCMD_AMOXOR:  res = a ^ b;
            mem_pkg::DCMD_AMOAND:  res = a & b;
            mem_pkg::DCMD_AMOOR:   res = a | b;
            mem_pkg::DCMD_AMOMIN:  res = ($signed(a) < $signed(b)) ? a : b;
            mem_pkg::DCMD_AMOMAX:  res = ($signed(a) > $signed(b)) ? a : b;
            mem_pkg::DCMD_AMOMINU: res = (a < b) ? a : b;
            mem_pkg::DCMD_AMOMAXU: res = (a > b) ? a : b;
            default:               res = b;   // Swap
        endcase
    end

    assign result_o = word_i ? {{32{res[31]}}, res[31:0]} : res;

endmodule

`default_nettype wire

// File: src/dcache_interface.sv
/* Turns one memory instruction into a data-cache request and holds the
   CPU until the cache answers, kills it, or raises an exception. */
`default_nettype none
`include "mem_params.svh"

module dcache_interface (
    input  wire                        clk_i,
    input  wire                        rstn_i,
    input  mem_pkg::req_cpu_dcache_t   req_cpu_dcache_i,
    // Cache answer
    input  mem_pkg::bus64_t            dmem_resp_data_i,
    input  logic                       dmem_req_ready_i,
    input  logic                       dmem_resp_valid_i,
    input  logic                       dmem_xcpt_ma_st_i,
    input  logic                       dmem_xcpt_ma_ld_i,
    input  logic                       dmem_xcpt_pf_st_i,
    input  logic                       dmem_xcpt_pf_ld_i,
    // Request to cache
    output logic                       dmem_req_valid_o,
    output mem_pkg::dcache_cmd_t       dmem_req_cmd_o,
    output mem_pkg::addr_t             dmem_req_addr_o,
    output logic [3:0]                 dmem_op_type_o,
    output mem_pkg::bus64_t            dmem_req_data_o,
    output logic [7:0]                 dmem_req_tag_o,
    output logic                       dmem_req_invalidate_lr_o,
    output logic                       dmem_req_kill_o,
    // Answer to CPU
    output mem_pkg::resp_dcache_cpu_t  resp_dcache_cpu_o
);

    mem_pkg::dcache_if_state_t state, next_state;
    mem_pkg::mem_op_t          type_of_op;
    mem_pkg::bus64_t           addr_64;
    logic mem_xcpt;
    logic io_address_space;
    logic kill_io_resp;
    logic kill_mem_ope;
    logic cpu_lock;
    logic xcpt_ma_st_q, xcpt_ma_ld_q, xcpt_pf_st_q, xcpt_pf_ld_q;

    // ------------------------------------------------------------------
    // Abort conditions
    // ------------------------------------------------------------------
    assign mem_xcpt = dmem_xcpt_ma_st_i | dmem_xcpt_ma_ld_i |
                      dmem_xcpt_pf_st_i | dmem_xcpt_pf_ld_i;

    // Device window sits just below RAM
    assign io_address_space = (dmem_req_addr_o >= req_cpu_dcache_i.io_base_addr) &
                              (dmem_req_addr_o < `DMEM_BASE);

    assign kill_io_resp = io_address_space & (type_of_op == mem_pkg::MEM_STORE); // Never answered
    assign kill_mem_ope = mem_xcpt | req_cpu_dcache_i.kill;

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state        <= mem_pkg::RESET_STATE;
            xcpt_ma_st_q <= 1'b0;
            xcpt_ma_ld_q <= 1'b0;
            xcpt_pf_st_q <= 1'b0;
            xcpt_pf_ld_q <= 1'b0;
        end else begin
            state        <= next_state;
            xcpt_ma_st_q <= dmem_xcpt_ma_st_i;   // One cycle later to the CPU
            xcpt_ma_ld_q <= dmem_xcpt_ma_ld_i;
            xcpt_pf_st_q <= dmem_xcpt_pf_st_i;
            xcpt_pf_ld_q <= dmem_xcpt_pf_ld_i;
        end
    end

    // Mealy outputs and next state
    always_comb begin
        dmem_req_valid_o = 1'b0;
        cpu_lock         = 1'b0;
        next_state       = state;
        case (state)
            mem_pkg::RESET_STATE: next_state = mem_pkg::IDLE;
            mem_pkg::IDLE: begin
                dmem_req_valid_o = !req_cpu_dcache_i.kill & req_cpu_dcache_i.valid &
                                   dmem_req_ready_i;
                cpu_lock         = req_cpu_dcache_i.valid;   // Stall while cache busy
                if (dmem_req_valid_o)
                    next_state = mem_pkg::MAKE_REQUEST;
                else if (req_cpu_dcache_i.kill)
                    next_state = mem_pkg::RESET_STATE;
            end
            mem_pkg::MAKE_REQUEST: begin
                cpu_lock   = 1'b1;
                next_state = kill_mem_ope ? mem_pkg::RESET_STATE : mem_pkg::WAIT_RESPONSE;
            end
            mem_pkg::WAIT_RESPONSE: begin
                if (dmem_resp_valid_i) begin
                    next_state = mem_pkg::IDLE;       // Lock falls with the answer
                end else begin
                    cpu_lock = 1'b1;
                    if (kill_mem_ope | kill_io_resp)
                        next_state = mem_pkg::RESET_STATE;
                end
            end
            default: next_state = mem_pkg::RESET_STATE;
        endcase
    end

    // ------------------------------------------------------------------
    // Instruction decode
    // ------------------------------------------------------------------
    always_comb begin
        dmem_req_cmd_o = mem_pkg::DCMD_LOAD;
        type_of_op     = mem_pkg::MEM_AMO;       // Most cases are AMOs
        case (req_cpu_dcache_i.instr_type)
            mem_pkg::AMO_LRW,   mem_pkg::AMO_LRD:   dmem_req_cmd_o = mem_pkg::DCMD_LR;
            mem_pkg::AMO_SCW,   mem_pkg::AMO_SCD:   dmem_req_cmd_o = mem_pkg::DCMD_SC;
            mem_pkg::AMO_SWAPW, mem_pkg::AMO_SWAPD: dmem_req_cmd_o = mem_pkg::DCMD_AMOSWAP;
            mem_pkg::AMO_ADDW,  mem_pkg::AMO_ADDD:  dmem_req_cmd_o = mem_pkg::DCMD_AMOADD;
            mem_pkg::AMO_XORW,  mem_pkg::AMO_XORD:  dmem_req_cmd_o = mem_pkg::DCMD_AMOXOR;
            mem_pkg::AMO_ANDW,  mem_pkg::AMO_ANDD:  dmem_req_cmd_o = mem_pkg::DCMD_AMOAND;
            mem_pkg::AMO_ORW,   mem_pkg::AMO_ORD:   dmem_req_cmd_o = mem_pkg::DCMD_AMOOR;
            mem_pkg::AMO_MINW,  mem_pkg::AMO_MIND:  dmem_req_cmd_o = mem_pkg::DCMD_AMOMIN;
            mem_pkg::AMO_MAXW,  mem_pkg::AMO_MAXD:  dmem_req_cmd_o = mem_pkg::DCMD_AMOMAX;
            mem_pkg::AMO_MINWU, mem_pkg::AMO_MINDU: dmem_req_cmd_o = mem_pkg::DCMD_AMOMINU;
            mem_pkg::AMO_MAXWU, mem_pkg::AMO_MAXDU: dmem_req_cmd_o = mem_pkg::DCMD_AMOMAXU;
            mem_pkg::LD, mem_pkg::LW, mem_pkg::LWU, mem_pkg::LH,
            mem_pkg::LHU, mem_pkg::LB, mem_pkg::LBU: begin
                dmem_req_cmd_o = mem_pkg::DCMD_LOAD;
                type_of_op     = mem_pkg::MEM_LOAD;
            end
            mem_pkg::SD, mem_pkg::SW, mem_pkg::SH, mem_pkg::SB: begin
                dmem_req_cmd_o = mem_pkg::DCMD_STORE;
                type_of_op     = mem_pkg::MEM_STORE;
            end
            default: type_of_op = mem_pkg::MEM_NOP;
        endcase
    end

    // AMOs carry no offset
    assign addr_64 = (type_of_op == mem_pkg::MEM_AMO) ? req_cpu_dcache_i.data_rs1 :
                     req_cpu_dcache_i.data_rs1 + req_cpu_dcache_i.imm;

    assign dmem_req_addr_o          = addr_64[39:0];
    assign dmem_op_type_o           = {1'b0, req_cpu_dcache_i.mem_size};
    assign dmem_req_data_o          = req_cpu_dcache_i.data_rs2;
    assign dmem_req_tag_o           = {2'b00, req_cpu_dcache_i.rd, 1'b0};  // Destination as tag
    assign dmem_req_invalidate_lr_o = req_cpu_dcache_i.kill;
    assign dmem_req_kill_o          = kill_mem_ope;

    // CPU response
    always_comb begin
        resp_dcache_cpu_o.ready      = dmem_resp_valid_i & (type_of_op != mem_pkg::MEM_STORE);
        resp_dcache_cpu_o.lock       = cpu_lock;
        resp_dcache_cpu_o.data       = dmem_resp_data_i;
        resp_dcache_cpu_o.addr       = addr_64;
        resp_dcache_cpu_o.xcpt_ma_st = xcpt_ma_st_q;
        resp_dcache_cpu_o.xcpt_ma_ld = xcpt_ma_ld_q;
        resp_dcache_cpu_o.xcpt_pf_st = xcpt_pf_st_q;
        resp_dcache_cpu_o.xcpt_pf_ld = xcpt_pf_ld_q;
    end

endmodule

`default_nettype wire

// File: src/dmem_scratchpad.sv
/* Blocking single-port data RAM standing in for the data cache.
   Fixed latency, LR/SC and AMOs, posted device writes below the RAM base. */
`default_nettype none
`include "mem_params.svh"

module dmem_scratchpad (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  logic                  req_valid_i,
    input  mem_pkg::dcache_cmd_t  req_cmd_i,
    input  mem_pkg::addr_t        req_addr_i,
    input  logic [3:0]            op_type_i,
    input  mem_pkg::bus64_t       req_data_i,
    input  logic [7:0]            req_tag_i,
    input  logic                  req_kill_i,
    input  logic                  invalidate_lr_i,
    output logic                  req_ready_o,
    output logic                  resp_valid_o,
    output mem_pkg::bus64_t       resp_data_o,
    output logic                  xcpt_ma_st_o,
    output logic                  xcpt_ma_ld_o,
    output logic                  xcpt_pf_st_o,
    output logic                  xcpt_pf_ld_o,
    output logic                  io_wr_valid_o,
    output mem_pkg::addr_t        io_wr_addr_o,
    output mem_pkg::bus64_t       io_wr_data_o
);

    localparam int WORDS = `DMEM_BYTES / 8;
    localparam int IDX_W = $clog2(WORDS);
    localparam int CNT_W = $clog2(`DMEM_LATENCY + 1);

    mem_pkg::bus64_t mem [WORDS];

    // Pending operation
    logic                 pending;
    logic [CNT_W-1:0]     cnt;
    mem_pkg::dcache_cmd_t p_cmd;
    mem_pkg::addr_t       p_addr;
    logic [2:0]           p_size;
    mem_pkg::bus64_t      p_data;
    logic                 resv_valid;
    mem_pkg::addr_t       resv_addr;

    logic accept, is_ld, is_st, in_ram, in_io, misal, fault, commit;
    logic is_amo, is_sc, sc_ok, wr_en;
    logic [2:0] align_mask;
    logic [7:0] be;
    mem_pkg::bus64_t rd_word, shifted, ld_ext, amo_res, wdata;

    // ------------------------------------------------------------------
    // Request checks
    // ------------------------------------------------------------------
    assign req_ready_o = !pending;
    assign accept      = req_valid_i & req_ready_o & !req_kill_i;
    assign is_ld       = (req_cmd_i == mem_pkg::DCMD_LOAD) | (req_cmd_i == mem_pkg::DCMD_LR);
    assign is_st       = (req_cmd_i == mem_pkg::DCMD_STORE);
    assign in_ram      = (req_addr_i >= `DMEM_BASE) & (req_addr_i < `DMEM_BASE + `DMEM_BYTES);
    assign in_io       = (req_addr_i >= `DMEM_IO_BASE) & (req_addr_i < `DMEM_BASE);
    assign fault       = !in_ram & !(in_io & is_st);   // Devices take plain stores only
    assign align_mask  = {op_type_i[1:0] == 2'd3, op_type_i[1], |op_type_i[1:0]};
    assign misal       = |(req_addr_i[2:0] & align_mask);

    // ------------------------------------------------------------------
    // Pending operation and commit
    // ------------------------------------------------------------------
    assign commit  = pending & !req_kill_i & (cnt == CNT_W'(`DMEM_LATENCY - 1));
    assign is_sc   = (p_cmd == mem_pkg::DCMD_SC);
    assign is_amo  = !(p_cmd inside {mem_pkg::DCMD_LOAD, mem_pkg::DCMD_STORE,
                                     mem_pkg::DCMD_LR, mem_pkg::DCMD_SC});
    // Reservation matches on the address of the LR
    assign sc_ok   = resv_valid & (resv_addr == p_addr);
    assign wr_en   = commit & ((p_cmd == mem_pkg::DCMD_STORE) | (is_sc & sc_ok) | is_amo);

    assign rd_word = mem[p_addr[3 +: IDX_W]];
    assign shifted = rd_word >> {p_addr[2:0], 3'b000};

    // Load extension, bit 2 of the size is unsigned
    always_comb begin
        case (p_size[1:0])
            2'd0:    ld_ext = p_size[2] ? {56'b0, shifted[7:0]} :
                                          {{56{shifted[7]}}, shifted[7:0]};
            2'd1:    ld_ext = p_size[2] ? {48'b0, shifted[15:0]} :
                                          {{48{shifted[15]}}, shifted[15:0]};
            2'd2:    ld_ext = p_size[2] ? {32'b0, shifted[31:0]} :
                                          {{32{shifted[31]}}, shifted[31:0]};
            default: ld_ext = shifted;
        endcase
        case (p_size[1:0])
            2'd0:    be = 8'h01;
            2'd1:    be = 8'h03;
            2'd2:    be = 8'h0f;
            default: be = 8'hff;
        endcase
        be = be << p_addr[2:0];
    end

    amo_alu u_amo_alu (
        .cmd_i      (p_cmd),
        .word_i     (p_size[1:0] == 2'd2),
        .mem_data_i (ld_ext),
        .operand_i  (p_data),
        .result_o   (amo_res)
    );

    assign wdata = (is_amo ? amo_res : p_data) << {p_addr[2:0], 3'b000};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending       <= 1'b0;
            cnt           <= '0;
            resp_valid_o  <= 1'b0;
            resv_valid    <= 1'b0;
            xcpt_ma_st_o  <= 1'b0;
            xcpt_ma_ld_o  <= 1'b0;
            xcpt_pf_st_o  <= 1'b0;
            xcpt_pf_ld_o  <= 1'b0;
            io_wr_valid_o <= 1'b0;
        end else begin
            // Exceptions and device writes land one cycle after the request
            xcpt_ma_ld_o  <= accept & misal & is_ld;
            xcpt_ma_st_o  <= accept & misal & !is_ld;
            xcpt_pf_ld_o  <= accept & !misal & fault & is_ld;
            xcpt_pf_st_o  <= accept & !misal & fault & !is_ld;
            io_wr_valid_o <= accept & !misal & in_io & is_st;
            resp_valid_o  <= commit;
            if (accept & !misal & in_ram) begin
                pending <= 1'b1;
                cnt     <= CNT_W'(1);
            end else if (commit | req_kill_i) begin
                pending <= 1'b0;   // Done or aborted
            end else if (pending) begin
                cnt <= cnt + 1'b1;
            end
            if (invalidate_lr_i | (commit & is_sc))
                resv_valid <= 1'b0;
            else if (commit & (p_cmd == mem_pkg::DCMD_LR))
                resv_valid <= 1'b1;
        end
    end

    // Payload and RAM
    always_ff @(posedge clk_i) begin
        if (accept) begin
            p_cmd        <= req_cmd_i;
            p_addr       <= req_addr_i;
            p_size       <= op_type_i[2:0];
            p_data       <= req_data_i;
            io_wr_addr_o <= req_addr_i;
            io_wr_data_o <= req_data_i;
        end
        if (commit & (p_cmd == mem_pkg::DCMD_LR))
            resv_addr <= p_addr;
        if (commit)
            resp_data_o <= is_sc ? {63'b0, !sc_ok} : ld_ext;  // SC answers 0 on success
        for (int i = 0; i < 8; i++) begin
            if (wr_en & be[i])
                mem[p_addr[3 +: IDX_W]][8*i +: 8] <= wdata[8*i +: 8];
        end
    end

endmodule

`default_nettype wire

// File: src/lsu_top.sv
/* Load/store unit: the cache interface joined to the data scratchpad.
   Exposes the CPU request and response and the device write port. */
`default_nettype none

module lsu_top (
    input  wire                        clk_i,
    input  wire                        rstn_i,
    input  mem_pkg::req_cpu_dcache_t   req_i,
    output mem_pkg::resp_dcache_cpu_t  resp_o,
    output logic                       io_wr_valid_o,
    output mem_pkg::addr_t             io_wr_addr_o,
    output mem_pkg::bus64_t            io_wr_data_o
);

    // Interface to scratchpad
    logic                 req_valid, req_kill, inv_lr, req_ready, resp_valid;
    logic                 ma_st, ma_ld, pf_st, pf_ld;
    mem_pkg::dcache_cmd_t req_cmd;
    mem_pkg::addr_t       req_addr;
    logic [3:0]           op_type;
    logic [7:0]           req_tag;
    mem_pkg::bus64_t      req_data, resp_data;

    dcache_interface u_dcache_interface (
        .clk_i                    (clk_i),
        .rstn_i                   (rstn_i),
        .req_cpu_dcache_i         (req_i),
        .dmem_resp_data_i         (resp_data),
        .dmem_req_ready_i         (req_ready),
        .dmem_resp_valid_i        (resp_valid),
        .dmem_xcpt_ma_st_i        (ma_st),
        .dmem_xcpt_ma_ld_i        (ma_ld),
        .dmem_xcpt_pf_st_i        (pf_st),
        .dmem_xcpt_pf_ld_i        (pf_ld),
        .dmem_req_valid_o         (req_valid),
        .dmem_req_cmd_o           (req_cmd),
        .dmem_req_addr_o          (req_addr),
        .dmem_op_type_o           (op_type),
        .dmem_req_data_o          (req_data),
        .dmem_req_tag_o           (req_tag),
        .dmem_req_invalidate_lr_o (inv_lr),
        .dmem_req_kill_o          (req_kill),
        .resp_dcache_cpu_o        (resp_o)
    );

    dmem_scratchpad u_dmem_scratchpad (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_valid_i     (req_valid),
        .req_cmd_i       (req_cmd),
        .req_addr_i      (req_addr),
        .op_type_i       (op_type),
        .req_data_i      (req_data),
        .req_tag_i       (req_tag),
        .req_kill_i      (req_kill),
        .invalidate_lr_i (inv_lr),
        .req_ready_o     (req_ready),
        .resp_valid_o    (resp_valid),
        .resp_data_o     (resp_data),
        .xcpt_ma_st_o    (ma_st),
        .xcpt_ma_ld_o    (ma_ld),
        .xcpt_pf_st_o    (pf_st),
        .xcpt_pf_ld_o    (pf_ld),
        .io_wr_valid_o   (io_wr_valid_o),
        .io_wr_addr_o    (io_wr_addr_o),
        .io_wr_data_o    (io_wr_data_o)
    );

endmodule

`default_nettype wire

// File: tests/lsu_assertions.sv
/* Protocol checks on the cache request and CPU response of the interface.
   Bound to every dcache_interface instance. */
`default_nettype none

module lsu_assertions (
    input wire  clk_i,
    input wire  rstn_i,
    input logic req_valid_i,     // Cache request strobe
    input logic req_ready_i,     // Scratchpad can take a request
    input logic lock_i,          // CPU held
    input logic resp_ready_i,    // Result to CPU
    input logic is_store_i       // Current instruction is a plain store
);

    timeunit 1ns;
    timeprecision 1ps;

    // Strobe only into a free scratchpad
    a_strobe_needs_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_i |-> req_ready_i)
        else $error("Request strobe issued while scratchpad not ready");

    // One cycle strobe
    a_strobe_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_i |=> !req_valid_i)
        else $error("Request strobe high two cycles in a row");

    a_lock_after_strobe: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_i |=> lock_i)
        else $error("CPU lock low in the cycle after a request strobe");

    // Stores end without a result
    a_no_ready_on_store: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(resp_ready_i && is_store_i))
        else $error("Response ready raised for a store");

endmodule

bind dcache_interface lsu_assertions u_lsu_assertions (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .req_valid_i  (dmem_req_valid_o),
    .req_ready_i  (dmem_req_ready_i),
    .lock_i       (resp_dcache_cpu_o.lock),
    .resp_ready_i (resp_dcache_cpu_o.ready),
    .is_store_i   (req_cpu_dcache_i.instr_type inside {mem_pkg::SD, mem_pkg::SW,
                                                       mem_pkg::SH, mem_pkg::SB})
);

`default_nettype wire

// File: tests/tb_lsu.sv
/* Testbench for lsu_top: runs the records of tests/lsu_tests.txt one by one
   and checks result, address, exception flags and device writes. */
`default_nettype none
`include "mem_params.svh"

module tb_lsu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_TESTS  = 64;
    localparam int REC_W      = 212;

    // One line of the test file, MSB first
    typedef struct packed {
        logic [7:0]  op;          // instr_type_t value
        logic [3:0]  size;        // mem_size
        logic [3:0]  kill;
        logic [39:0] rs1;
        logic [63:0] rs2;
        logic [15:0] imm;         // Sign-extended
        logic [63:0] exp_data;
        logic [7:0]  exp_flags;   // {pf_ld, pf_st, ma_ld, ma_st, ready}
        logic [3:0]  exp_io;      // One device write expected
    } test_rec_t;

    logic clk_i = 1'b0;
    logic rstn_i;
    mem_pkg::req_cpu_dcache_t  req;
    mem_pkg::resp_dcache_cpu_t resp;
    logic            io_wr_valid;
    mem_pkg::addr_t  io_wr_addr;
    mem_pkg::bus64_t io_wr_data;

    logic [REC_W-1:0] test_mem [MAX_TESTS];
    int          num_tests = 0;
    int          cur_test  = 0;
    int          errors    = 0;
    logic        loaded    = 1'b0;
    logic [31:0] seed      = 32'd28524;

    lsu_top UUT (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_i         (req),
        .resp_o        (resp),
        .io_wr_valid_o (io_wr_valid),
        .io_wr_addr_o  (io_wr_addr),
        .io_wr_data_o  (io_wr_data)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Idle gap generator
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch in test %0d on %s: got %h, expected %h",
                     cur_test, name, got, exp);
        end
    endtask

    // Drive one record and follow it until lock falls
    task automatic run_test(input test_rec_t rec);
        logic [63:0] imm_ext, exp_addr, got_data, got_addr;
        logic [7:0]  got_flags;
        int          ready_cnt, io_cnt;
        logic [39:0] got_io_addr;
        logic [63:0] got_io_data;
        imm_ext     = {{48{rec.imm[15]}}, rec.imm};
        exp_addr    = (rec.op >= 8'h0b) ? {24'b0, rec.rs1} : {24'b0, rec.rs1} + imm_ext;
        got_data    = '0;
        got_addr    = '0;
        got_flags   = '0;
        ready_cnt   = 0;
        io_cnt      = 0;
        got_io_addr = '0;
        got_io_data = '0;
        @(posedge clk_i);
        req.valid        <= 1'b1;
        req.kill         <= rec.kill[0];
        req.instr_type   <= mem_pkg::instr_type_t'(rec.op[5:0]);
        req.data_rs1     <= {24'b0, rec.rs1};
        req.data_rs2     <= rec.rs2;
        req.imm          <= imm_ext;
        req.mem_size     <= rec.size[2:0];
        req.rd           <= 5'd1;
        req.io_base_addr <= `DMEM_IO_BASE;
        do begin
            @(negedge clk_i);                     // Mid-cycle, outputs settled
            if (resp.ready) begin
                ready_cnt++;
                got_data = resp.data;
            end
            if (io_wr_valid) begin
                io_cnt++;
                got_io_addr = io_wr_addr;
                got_io_data = io_wr_data;
            end
            got_flags = got_flags | {3'b0, resp.xcpt_pf_ld, resp.xcpt_pf_st,
                                     resp.xcpt_ma_ld, resp.xcpt_ma_st, resp.ready};
            got_addr = resp.addr;
        end while (resp.lock);
        @(posedge clk_i);
        req.valid <= 1'b0;                        // Lock fell this cycle
        req.kill  <= 1'b0;
        check_value("resp_o flags", 64'(got_flags), 64'(rec.exp_flags));
        check_value("resp_o.ready count", 64'(ready_cnt), 64'(rec.exp_flags[0]));
        check_value("resp_o.addr", got_addr, exp_addr);
        if (rec.exp_flags[0])
            check_value("resp_o.data", got_data, rec.exp_data);
        check_value("io_wr_valid_o count", 64'(io_cnt), 64'(rec.exp_io));
        if (rec.exp_io != 0) begin
            check_value("io_wr_addr_o", 64'(got_io_addr), exp_addr);
            check_value("io_wr_data_o", got_io_data, rec.rs2);
        end
    endtask

    // ------------------------------------------------------------------
    // Watchdog, 20 cycles per test plus reset
    // ------------------------------------------------------------------
    initial begin
        wait (loaded);
        #((num_tests * 20 + 10) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", num_tests * 20 + 10);
        $display("Test failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        req    = '0;
        rstn_i = 1'b0;
        for (int i = 0; i < MAX_TESTS; i++)
            test_mem[i] = '1;                     // All ones marks end of file
        $readmemh("tests/lsu_tests.txt", test_mem);
        while (num_tests < MAX_TESTS && test_mem[num_tests] != '1)
            num_tests++;
        loaded = 1'b1;
        if (num_tests == 0) begin
            errors++;
            $display("No test records could be read from tests/lsu_tests.txt");
        end
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);
        for (int i = 0; i < num_tests; i++) begin
            cur_test = i;
            run_test(test_rec_t'(test_mem[i]));
            seed = lcg_next(seed);
            repeat (seed[17:16]) @(posedge clk_i);   // 0 to 3 idle cycles
        end
        repeat (2) @(posedge clk_i);
        $display("%0d tests run, %0d errors", num_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/lsu_tests.txt
// op_size_kill_rs1_rs2_imm_expdata_flags_io, flags = {pf_ld,pf_st,ma_ld,ma_st,ready}
// Address is rs1 + imm, rs1 alone for LR, SC and AMOs
07_3_0_0080000000_8899aabbccddeeff_0008_0000000000000000_00_0
00_3_0_0080000000_0000000000000000_0008_8899aabbccddeeff_01_0
01_2_0_0080000000_0000000000000000_000c_ffffffff8899aabb_01_0
02_6_0_0080000000_0000000000000000_000c_000000008899aabb_01_0
03_1_0_0080000000_0000000000000000_000a_ffffffffffffccdd_01_0
04_5_0_0080000000_0000000000000000_000e_0000000000008899_01_0
05_0_0_0080000000_0000000000000000_0009_ffffffffffffffee_01_0
06_4_0_0080000000_0000000000000000_000f_0000000000000088_01_0
08_2_0_0080000000_1122334455667788_0010_0000000000000000_00_0
09_1_0_0080000000_000000000000c3d2_0014_0000000000000000_00_0
0a_0_0_0080000000_00000000000000a5_0016_0000000000000000_00_0
0a_0_0_0080000000_000000000000005a_0017_0000000000000000_00_0
00_3_0_0080000000_0000000000000000_0010_5aa5c3d255667788_01_0
07_3_0_0080000020_0000000100000005_0000_0000000000000000_00_0
12_3_0_0080000020_0000000000000003_0000_0000000100000005_01_0
19_2_0_0080000020_00000000fffffffe_0000_0000000000000008_01_0
20_3_0_0080000020_0000000200000000_0000_00000001fffffffe_01_0
0f_2_0_0080000024_00000000deadbeef_0000_0000000000000002_01_0
0c_3_0_0080000020_0000000000000000_0000_deadbeef00000000_01_0
0e_3_0_0080000020_0000000000005555_0000_0000000000000000_01_0
0e_3_0_0080000020_0000000000006666_0000_0000000000000001_01_0
0b_2_0_0080000020_0000000000000000_0000_0000000000005555_01_0
07_3_1_0080000000_0000000000000000_0008_0000000000000000_00_0
0d_2_0_0080000020_0000000000000077_0000_0000000000000001_01_0
00_3_0_0080000020_0000000000000000_0000_0000000000005555_01_0
01_2_0_0080000000_0000000000000000_0002_0000000000000000_04_0
09_1_0_0080000000_000000000000ffff_0009_0000000000000000_02_0
00_3_0_0080000000_0000000000000000_0200_0000000000000000_10_0
07_3_0_0030000000_00000000000000ff_0000_0000000000000000_08_0
00_3_0_0080000000_0000000000000000_0008_8899aabbccddeeff_01_0
07_3_0_0040001000_0123456789abcdef_0010_0000000000000000_00_1

// File: files.f
+incdir+include
src/mem_pkg.sv
src/amo_alu.sv
src/dcache_interface.sv
src/dmem_scratchpad.sv
src/lsu_top.sv
tests/lsu_assertions.sv
tests/tb_lsu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_lsu \
    -Mdir obj_dir -o tb_lsu > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_lsu > sim.log 2>&1 && sim_ok=1 || sim_ok=0
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
[ "$sim_ok" -eq 1 ] && grep -q "Test completed successfully" sim.log && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
